//--- logic/rx_types_pkg.sv
package rx_types_pkg;

    // widths of the receiver slice
    localparam int SAMPLE_W = 32;
    localparam int PHASE_W  = 20;
    localparam int COUNT_W  = 32;
    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 8;

    // complex sample, Q in upper half, I in lower half
    typedef logic [SAMPLE_W-1:0] sample_t;

    // phase word and frequency correction, wrap mod 2^20
    typedef logic [PHASE_W-1:0]  phase_t;

    typedef logic [COUNT_W-1:0]  count_t;
    typedef logic [DATA_W-1:0]   reg_data_t;
    typedef logic [ADDR_W-1:0]   reg_addr_t;

endpackage

//--- logic/rx_regmap_pkg.sv
package rx_regmap_pkg;

    // register byte addresses
    localparam rx_types_pkg::reg_addr_t ADDR_CTRL        = 8'h00;
    localparam rx_types_pkg::reg_addr_t ADDR_SAMPLE_CNT  = 8'h04;
    localparam rx_types_pkg::reg_addr_t ADDR_CORRECTION  = 8'h08;
    localparam rx_types_pkg::reg_addr_t ADDR_PHASE       = 8'h0C;
    localparam rx_types_pkg::reg_addr_t ADDR_LAST_SAMPLE = 8'h10;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // AXI-Lite slave states
    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        WRITE_RESP,
        READ,
        READ_RESP
    } axil_state_t;

endpackage

//--- logic/reg_bus_if.sv
`timescale 1ns/1ns

interface reg_bus_if;
    import rx_types_pkg::*;

    logic      wr_en;
    reg_addr_t wr_addr;
    reg_data_t wr_data;
    reg_addr_t rd_addr;
    reg_data_t rd_data;

    // bus side, drives the strobes
    modport slave (
        output wr_en, wr_addr, wr_data, rd_addr,
        input  rd_data
    );

    // register file side
    modport regs (
        input  wr_en, wr_addr, wr_data, rd_addr,
        output rd_data
    );

endinterface

//--- logic/axil_slave_fsm.sv
`timescale 1ns/1ns

module axil_slave_fsm (
    input  logic                     clk_i,
    input  logic                     reset_ni,

    input  rx_types_pkg::reg_addr_t  awaddr_i,
    input  logic                     awvalid_i,
    output logic                     awready_o,
    input  rx_types_pkg::reg_data_t  wdata_i,
    input  logic                     wvalid_i,
    output logic                     wready_o,
    output logic [1:0]               bresp_o,
    output logic                     bvalid_o,
    input  logic                     bready_i,

    input  rx_types_pkg::reg_addr_t  araddr_i,
    input  logic                     arvalid_i,
    output logic                     arready_o,
    output rx_types_pkg::reg_data_t  rdata_o,
    output logic [1:0]               rresp_o,
    output logic                     rvalid_o,
    input  logic                     rready_i,

    reg_bus_if.slave                 bus_o
);
    import rx_types_pkg::*;
    import rx_regmap_pkg::*;

    axil_state_t state;
    axil_state_t state_next;
    reg_addr_t   addr_q;
    reg_data_t   wdata_q;
    reg_data_t   rdata_q;
    logic        write_go;
    logic        read_go;

    // write needs both address and data, and beats a read
    assign write_go = (state == IDLE) && awvalid_i && wvalid_i;
    assign read_go  = (state == IDLE) && arvalid_i && !(awvalid_i && wvalid_i);

    // ------------------------------
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (write_go) begin
                    state_next = WRITE;
                end else if (read_go) begin
                    state_next = READ;
                end
            end
            WRITE:      state_next = WRITE_RESP;
            WRITE_RESP: if (bready_i) state_next = IDLE;
            READ:       state_next = READ_RESP;
            READ_RESP:  if (rready_i) state_next = IDLE;
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // captured address and data
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            addr_q  <= '0;
            wdata_q <= '0;
            rdata_q <= '0;
        end else begin
            if (write_go) begin
                addr_q  <= awaddr_i;
                wdata_q <= wdata_i;
            end else if (read_go) begin
                addr_q  <= araddr_i;
            end
            if (state == READ) begin
                rdata_q <= bus_o.rd_data;
            end
        end
    end

    // ------------------------------
    assign awready_o = write_go;
    assign wready_o  = write_go;
    assign arready_o = read_go;

    assign bvalid_o  = (state == WRITE_RESP);
    assign bresp_o   = RESP_OKAY;
    assign rvalid_o  = (state == READ_RESP);
    assign rresp_o   = RESP_OKAY;
    assign rdata_o   = rdata_q;

    assign bus_o.wr_en   = (state == WRITE);
    assign bus_o.wr_addr = addr_q;
    assign bus_o.wr_data = wdata_q;
    assign bus_o.rd_addr = addr_q;

endmodule

//--- logic/sample_counter.sv
`timescale 1ns/1ns

module sample_counter (
    input  logic                  clk_i,
    input  logic                  reset_ni,
    input  logic                  sample_valid_i,
    input  logic                  clear_i,
    output rx_types_pkg::count_t  count_o
);

    // clear has priority over counting
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            count_o <= '0;
        end else if (clear_i) begin
            count_o <= '0;
        end else if (sample_valid_i) begin
            count_o <= count_o + 1'b1;
        end
    end

endmodule

//--- logic/cfo_phase_accum.sv
`timescale 1ns/1ns

module cfo_phase_accum (
    input  logic                  clk_i,
    input  logic                  reset_ni,
    input  logic                  sample_valid_i,
    input  rx_types_pkg::phase_t  cfo_inc_i,
    input  logic                  cfo_valid_i,
    input  logic                  manual_mode_i,
    output rx_types_pkg::phase_t  correction_o,
    output rx_types_pkg::phase_t  phase_o
);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            correction_o <= '0;
            phase_o      <= '0;
        end else if (manual_mode_i) begin
            // manual CFO mode, no tracking
            correction_o <= '0;
            phase_o      <= '0;
        end else begin
            // increments are relative to the current correction
            if (cfo_valid_i) begin
                correction_o <= correction_o - cfo_inc_i;
            end
            // phase sees the old correction on a coinciding increment
            if (sample_valid_i) begin
                phase_o <= phase_o + correction_o;
            end
        end
    end

endmodule

//--- logic/rx_status_regs.sv
`timescale 1ns/1ns

module rx_status_regs (
    input  logic                  clk_i,
    input  logic                  reset_ni,

    reg_bus_if.regs               bus_i,

    input  rx_types_pkg::sample_t sample_i,
    input  logic                  sample_valid_i,
    input  rx_types_pkg::count_t  count_i,
    input  rx_types_pkg::phase_t  correction_i,
    input  rx_types_pkg::phase_t  phase_i,

    output logic                  manual_mode_o,
    output logic                  cnt_clear_o
);
    import rx_types_pkg::*;
    import rx_regmap_pkg::*;

    sample_t last_sample;

    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            manual_mode_o <= 1'b0;
        end else if (bus_i.wr_en && bus_i.wr_addr == ADDR_CTRL) begin
            manual_mode_o <= bus_i.wr_data[0];
        end
    end

    // any write to the count register clears it
    assign cnt_clear_o = bus_i.wr_en && (bus_i.wr_addr == ADDR_SAMPLE_CNT);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            last_sample <= '0;
        end else if (sample_valid_i) begin
            last_sample <= sample_i;
        end
    end

    // ------------------------------
    always_comb begin
        case (bus_i.rd_addr)
            ADDR_CTRL:        bus_i.rd_data = reg_data_t'(manual_mode_o);
            ADDR_SAMPLE_CNT:  bus_i.rd_data = reg_data_t'(count_i);
            ADDR_CORRECTION:  bus_i.rd_data = reg_data_t'(correction_i);
            ADDR_PHASE:       bus_i.rd_data = reg_data_t'(phase_i);
            ADDR_LAST_SAMPLE: bus_i.rd_data = reg_data_t'(last_sample);
            // unmapped
            default:          bus_i.rd_data = '0;
        endcase
    end

endmodule

//--- logic/cfo_rx_top.sv
`timescale 1ns/1ns

module cfo_rx_top (
    input  logic                     clk_i,
    input  logic                     reset_ni,

    input  rx_types_pkg::sample_t    sample_i,
    input  logic                     sample_valid_i,
    input  rx_types_pkg::phase_t     cfo_inc_i,
    input  logic                     cfo_valid_i,

    input  rx_types_pkg::reg_addr_t  s_axil_awaddr_i,
    input  logic                     s_axil_awvalid_i,
    output logic                     s_axil_awready_o,
    input  rx_types_pkg::reg_data_t  s_axil_wdata_i,
    input  logic                     s_axil_wvalid_i,
    output logic                     s_axil_wready_o,
    output logic [1:0]               s_axil_bresp_o,
    output logic                     s_axil_bvalid_o,
    input  logic                     s_axil_bready_i,
    input  rx_types_pkg::reg_addr_t  s_axil_araddr_i,
    input  logic                     s_axil_arvalid_i,
    output logic                     s_axil_arready_o,
    output rx_types_pkg::reg_data_t  s_axil_rdata_o,
    output logic [1:0]               s_axil_rresp_o,
    output logic                     s_axil_rvalid_o,
    input  logic                     s_axil_rready_i,

    output rx_types_pkg::phase_t     phase_o,
    output rx_types_pkg::phase_t     correction_o
);
    import rx_types_pkg::*;

    count_t sample_count;
    logic   manual_mode;
    logic   cnt_clear;

    reg_bus_if reg_bus ();

    // ------------------------------
    axil_slave_fsm axil_slave_fsm_inst (
        .clk_i     (clk_i),
        .reset_ni  (reset_ni),
        .awaddr_i  (s_axil_awaddr_i),
        .awvalid_i (s_axil_awvalid_i),
        .awready_o (s_axil_awready_o),
        .wdata_i   (s_axil_wdata_i),
        .wvalid_i  (s_axil_wvalid_i),
        .wready_o  (s_axil_wready_o),
        .bresp_o   (s_axil_bresp_o),
        .bvalid_o  (s_axil_bvalid_o),
        .bready_i  (s_axil_bready_i),
        .araddr_i  (s_axil_araddr_i),
        .arvalid_i (s_axil_arvalid_i),
        .arready_o (s_axil_arready_o),
        .rdata_o   (s_axil_rdata_o),
        .rresp_o   (s_axil_rresp_o),
        .rvalid_o  (s_axil_rvalid_o),
        .rready_i  (s_axil_rready_i),
        .bus_o     (reg_bus)
    );

    rx_status_regs rx_status_regs_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .bus_i          (reg_bus),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .count_i        (sample_count),
        .correction_i   (correction_o),
        .phase_i        (phase_o),
        .manual_mode_o  (manual_mode),
        .cnt_clear_o    (cnt_clear)
    );

    // ------------------------------
    sample_counter sample_counter_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_valid_i (sample_valid_i),
        .clear_i        (cnt_clear),
        .count_o        (sample_count)
    );

    cfo_phase_accum cfo_phase_accum_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_valid_i (sample_valid_i),
        .cfo_inc_i      (cfo_inc_i),
        .cfo_valid_i    (cfo_valid_i),
        .manual_mode_i  (manual_mode),
        .correction_o   (correction_o),
        .phase_o        (phase_o)
    );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic reset_no
);

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // reset low for the first 3 rising edges
    initial begin
        reset_no = 1'b0;
        repeat (3) @(posedge clk_o);
        reset_no <= 1'b1;
    end

endmodule

//--- tests/cfo_rx_tb.sv
`timescale 1ns/1ns

module cfo_rx_tb;
    import rx_types_pkg::*;
    import rx_regmap_pkg::*;

    localparam int STEP_CYCLES = 40;

    typedef enum logic [2:0] {OP_SAMPLES, OP_CFO, OP_BOTH, OP_WRITE, OP_READ} op_e;
    typedef struct packed {
        op_e        op;
        reg_data_t  val;
        reg_addr_t  addr;
        logic [3:0] stall;
        logic       exp_en;
        reg_data_t  exp;
    } step_t;

    logic       clk_i, reset_ni, sample_valid_i, cfo_valid_i;
    sample_t    sample_i;
    phase_t     cfo_inc_i, phase_o, correction_o;
    reg_addr_t  s_axil_awaddr_i, s_axil_araddr_i;
    reg_data_t  s_axil_wdata_i, s_axil_rdata_o;
    logic       s_axil_awvalid_i, s_axil_wvalid_i, s_axil_bready_i, s_axil_arvalid_i;
    logic       s_axil_rready_i, s_axil_awready_o, s_axil_wready_o, s_axil_bvalid_o;
    logic       s_axil_arready_o, s_axil_rvalid_o;
    logic [1:0] s_axil_bresp_o, s_axil_rresp_o;

    step_t      steps[$];
    integer     seed;
    int         errors;
    // reference model state
    phase_t     m_corr, m_phase;
    count_t     m_count;
    sample_t    m_last;
    logic       m_manual;

    tb_clock_gen tb_clock_gen_inst (.clk_o(clk_i), .reset_no(reset_ni));
    cfo_rx_top cfo_rx_top_inst (.*);

    task automatic check_value(input string name, input reg_data_t exp, input reg_data_t act);
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic add_step(input op_e op, input reg_data_t val, input reg_addr_t addr,
                            input int stall, input logic exp_en, input reg_data_t exp);
        steps.push_back(step_t'({op, val, addr, 4'(stall), exp_en, exp}));
    endtask

    function automatic reg_data_t model_read(input reg_addr_t addr);
        case (addr)
            ADDR_CTRL:        return reg_data_t'(m_manual);
            ADDR_SAMPLE_CNT:  return m_count;
            ADDR_CORRECTION:  return reg_data_t'(m_corr);
            ADDR_PHASE:       return reg_data_t'(m_phase);
            ADDR_LAST_SAMPLE: return m_last;
            default:          return '0;
        endcase
    endfunction

    // ------------------------------
    // one data path cycle, phase uses the old correction
    task automatic data_cycle(input logic smp, input logic cfo, input phase_t inc);
        sample_t d;
        d = $random(seed);
        sample_i       <= d;
        sample_valid_i <= smp;
        cfo_inc_i      <= inc;
        cfo_valid_i    <= cfo;
        if (smp) begin
            m_count = m_count + 32'd1;
            m_last  = d;
            m_phase = m_manual ? '0 : m_phase + m_corr;
        end
        if (cfo && !m_manual) begin
            m_corr = m_corr - inc;
        end
        @(posedge clk_i);
    endtask

    // single AXI-Lite write or read, response held off for stall cycles
    task automatic axi_access(input logic wr, input reg_addr_t addr, input reg_data_t data,
                              input int stall, output reg_data_t rdata);
        s_axil_awaddr_i  <= addr;
        s_axil_araddr_i  <= addr;
        s_axil_wdata_i   <= data;
        s_axil_awvalid_i <= wr;
        s_axil_wvalid_i  <= wr;
        s_axil_arvalid_i <= !wr;
        @(negedge clk_i);
        while (!((s_axil_awready_o && s_axil_wready_o) || s_axil_arready_o)) @(negedge clk_i);
        @(posedge clk_i);
        {s_axil_awvalid_i, s_axil_wvalid_i, s_axil_arvalid_i} <= 3'b000;
        @(negedge clk_i);
        // address and data ready last one cycle only
        check_value("ready pulse", 32'd0,
                    32'({s_axil_awready_o, s_axil_wready_o, s_axil_arready_o}));
        while (!(s_axil_bvalid_o || s_axil_rvalid_o)) @(negedge clk_i);
        repeat (stall) begin
            @(negedge clk_i);
            check_value("response held", 32'd1, 32'(wr ? s_axil_bvalid_o : s_axil_rvalid_o));
        end
        @(posedge clk_i);
        {s_axil_bready_i, s_axil_rready_i} <= 2'b11;
        @(negedge clk_i);
        check_value("response code", 32'(RESP_OKAY), 32'(wr ? s_axil_bresp_o : s_axil_rresp_o));
        rdata = s_axil_rdata_o;
        @(posedge clk_i);
        {s_axil_bready_i, s_axil_rready_i} <= 2'b00;
    endtask

    // ------------------------------
    initial begin
        step_t     st;
        reg_data_t rd_word;
        seed   = 32'h63ad3945;
        errors = 0;
        {m_corr, m_phase, m_count, m_last, m_manual} = '0;
        {sample_i, sample_valid_i, cfo_inc_i, cfo_valid_i} <= '0;
        {s_axil_awaddr_i, s_axil_awvalid_i, s_axil_wdata_i, s_axil_wvalid_i} <= '0;
        {s_axil_bready_i, s_axil_araddr_i, s_axil_arvalid_i, s_axil_rready_i} <= '0;

        // op, value or count, address, stall cycles, literal check, literal value
        add_step(OP_READ,    32'h0,        ADDR_CTRL,        0, 1'b1, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_SAMPLE_CNT,  0, 1'b1, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_CORRECTION,  0, 1'b1, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_PHASE,       0, 1'b1, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_LAST_SAMPLE, 0, 1'b1, 32'h0);
        add_step(OP_SAMPLES, 32'd12,       ADDR_CTRL,        0, 1'b0, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_SAMPLE_CNT,  0, 1'b1, 32'd12);
        add_step(OP_WRITE,   32'h5,        ADDR_SAMPLE_CNT,  0, 1'b0, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_SAMPLE_CNT,  0, 1'b1, 32'h0);
        add_step(OP_CFO,     32'h0_0123,   ADDR_CTRL,        0, 1'b0, 32'h0);
        add_step(OP_CFO,     32'h0_4560,   ADDR_CTRL,        0, 1'b0, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_CORRECTION,  0, 1'b1, 32'h000F_B97D);
        add_step(OP_SAMPLES, 32'd7,        ADDR_CTRL,        0, 1'b0, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_PHASE,       0, 1'b0, 32'h0);
        add_step(OP_BOTH,    32'h0_0F00,   ADDR_CTRL,        0, 1'b0, 32'h0);
        add_step(OP_SAMPLES, 32'd3,        ADDR_CTRL,        0, 1'b0, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_PHASE,       0, 1'b0, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_CORRECTION,  0, 1'b1, 32'h000F_AA7D);
        add_step(OP_WRITE,   32'h1,        ADDR_CTRL,        0, 1'b0, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_CTRL,        0, 1'b1, 32'h1);
        add_step(OP_CFO,     32'h0_0777,   ADDR_CTRL,        0, 1'b0, 32'h0);
        add_step(OP_SAMPLES, 32'd5,        ADDR_CTRL,        0, 1'b0, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_CORRECTION,  0, 1'b1, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_PHASE,       0, 1'b1, 32'h0);
        add_step(OP_WRITE,   32'h0,        ADDR_CTRL,        0, 1'b0, 32'h0);
        add_step(OP_CFO,     32'h0_0200,   ADDR_CTRL,        0, 1'b0, 32'h0);
        add_step(OP_SAMPLES, 32'd4,        ADDR_CTRL,        0, 1'b0, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_PHASE,       0, 1'b0, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_CORRECTION,  0, 1'b1, 32'h000F_FE00);
        add_step(OP_SAMPLES, 32'd2,        ADDR_CTRL,        0, 1'b0, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_LAST_SAMPLE, 4, 1'b0, 32'h0);
        add_step(OP_WRITE,   32'hDEAD_BEEF, 8'h20,           5, 1'b0, 32'h0);
        add_step(OP_READ,    32'h0,        8'h20,            0, 1'b1, 32'h0);
        add_step(OP_READ,    32'h0,        ADDR_SAMPLE_CNT,  3, 1'b1, 32'd22);

        wait (reset_ni === 1'b1);
        foreach (steps[i]) begin
            st = steps[i];
            @(posedge clk_i);
            case (st.op)
                OP_SAMPLES: begin
                    repeat (st.val) begin
                        repeat ($random(seed) & 3) data_cycle(1'b0, 1'b0, '0);
                        data_cycle(1'b1, 1'b0, '0);
                    end
                end
                OP_CFO:  data_cycle(1'b0, 1'b1, st.val[PHASE_W-1:0]);
                OP_BOTH: data_cycle(1'b1, 1'b1, st.val[PHASE_W-1:0]);
                OP_WRITE: begin
                    axi_access(1'b1, st.addr, st.val, int'(st.stall), rd_word);
                    if (st.addr == ADDR_SAMPLE_CNT) m_count = '0;
                    if (st.addr == ADDR_CTRL) m_manual = st.val[0];
                    if (m_manual) {m_corr, m_phase} = '0;
                end
                default: begin
                    axi_access(1'b0, st.addr, '0, int'(st.stall), rd_word);
                    check_value($sformatf("step %0d read %h", i, st.addr),
                                model_read(st.addr), rd_word);
                    if (st.exp_en) begin
                        check_value($sformatf("step %0d table %h", i, st.addr), st.exp, rd_word);
                    end
                end
            endcase
            // idle data on the sample bus, must not reach the latch
            sample_i <= $random(seed);
            {sample_valid_i, cfo_valid_i} <= 2'b00;
            @(negedge clk_i);
            check_value($sformatf("step %0d phase_o", i), 32'(m_phase), 32'(phase_o));
            check_value($sformatf("step %0d correction_o", i), 32'(m_corr), 32'(correction_o));
        end
        $display("%0d errors over %0d steps", errors, steps.size());
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog sized from the table
    initial begin
        #1;
        repeat (steps.size() * STEP_CYCLES) @(posedge clk_i);
        $display("timeout: the table did not finish in %0d cycles", steps.size() * STEP_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- filelist.f
logic/rx_types_pkg.sv
logic/rx_regmap_pkg.sv
logic/reg_bus_if.sv
logic/axil_slave_fsm.sv
logic/sample_counter.sv
logic/cfo_phase_accum.sv
logic/rx_status_regs.sv
logic/cfo_rx_top.sv
tests/tb_clock_gen.sv
tests/cfo_rx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module cfo_rx_tb -f filelist.f \
    && ./obj_dir/Vcfo_rx_tb | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "result: pass" \
    || { echo "result: fail"; exit 1; }
